// File: striped_mem_rd.f
src/stripe_pkg.sv
src/axi_rd_if.sv
src/axi_stripe_rd.sv
src/stripe_bank.sv
src/striped_mem_rd.sv
bench/clk_gen.sv
bench/tb_striped_mem_rd.sv

// File: run_sim.sh
#!/bin/sh
# Build the bench with Verilator, run it and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 \
  --top-module tb_striped_mem_rd \
  -f striped_mem_rd.f \
  && ./obj_dir/Vtb_striped_mem_rd > sim.log 2>&1 \
  || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qF "*** PASSED ***" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// File: mem_image.hex
// one 32-bit word per line, word i = {i, 3c, ~i, i ^ 5a}
003CFF5A
013CFE5B
023CFD58
033CFC59
043CFB5E
053CFA5F
063CF95C
073CF85D
083CF752
093CF653
0A3CF550
0B3CF451
0C3CF356
0D3CF257
0E3CF154
0F3CF055
103CEF4A
113CEE4B
123CED48
133CEC49
143CEB4E
153CEA4F
163CE94C
173CE84D
183CE742
193CE643
1A3CE540
1B3CE441
1C3CE346
1D3CE247
1E3CE144
1F3CE045
203CDF7A
213CDE7B
223CDD78
233CDC79
243CDB7E
253CDA7F
263CD97C
273CD87D
283CD772
293CD673
2A3CD570
2B3CD471
2C3CD376
2D3CD277
2E3CD174
2F3CD075
303CCF6A
313CCE6B
323CCD68
333CCC69
343CCB6E
353CCA6F
363CC96C
373CC86D
383CC762
393CC663
3A3CC560
3B3CC461
3C3CC366
3D3CC267
3E3CC164
3F3CC065

// File: bench/tb_striped_mem_rd.sv
module tb_striped_mem_rd import stripe_pkg::*; ();
  localparam int PERIOD = 100;
  localparam int SEED = 70398;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_BURSTS = 60;
  localparam int MAX_BEATS = 16;
  localparam int STALL_FACTOR = 4;
  // worst case burst length stretched by back-pressure plus the reset phase
  localparam int WATCHDOG_TIME =
    (NUM_BURSTS * MAX_BEATS * STALL_FACTOR + RESET_CYCLES) * PERIOD;

  logic clk;
  logic rst_n;
  logic arvalid;
  logic arready;
  logic [ID_W-1:0] arid;
  logic [ADDR_W-1:0] araddr;
  logic [LEN_W-1:0] arlen;
  logic [SIZE_W-1:0] arsize;
  logic [BURST_W-1:0] arburst;
  logic rvalid;
  logic rready;
  logic [ID_W-1:0] rid;
  logic [DATA_W-1:0] rdata;
  logic [RESP_W-1:0] rresp;
  logic rlast;
  // reference copy of the memory image indexed by top level word address
  logic [DATA_W-1:0] image [IMAGE_WORDS];
  int errors;
  int tests_run;
  int tests_failed;

  clk_gen i_clk_gen (.clk(clk));

  striped_mem_rd i_striped_mem_rd (.*);

  // --------------------------------------------------
  // reporting
  // --------------------------------------------------

  // a test failed if it added to the error count
  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // both ports must be idle before the first request
  task automatic check_reset_state();
    int errors_before;
    errors_before = errors;
    @(posedge clk);
    if (arready !== 1'b1) begin
      $display("Mismatch arready after reset: got %h expected %h", arready, 1'b1);
      errors++;
    end
    if (rvalid !== 1'b0) begin
      $display("Mismatch rvalid after reset: got %h expected %h", rvalid, 1'b0);
      errors++;
    end
    report_test("reset state", errors_before);
  endtask

  // --------------------------------------------------
  // one random burst issued and checked beat by beat
  // --------------------------------------------------
  task automatic run_burst(input int n);
    int errors_before;
    int idle;
    int word;
    int beat;
    bit done;
    bit held;
    logic [ID_W-1:0] id;
    logic [LEN_W-1:0] len;
    logic [DATA_W-1:0] held_data;
    logic [DATA_W-1:0] expected;
    errors_before = errors;
    id = ID_W'($urandom);
    // start on a stripe and run for one, two or four stripes
    word = int'($urandom % (IMAGE_WORDS / NUM_BANKS)) * NUM_BANKS;
    len = LEN_W'((NUM_BANKS << ($urandom % 3)) - 1);
    idle = int'($urandom % 4);
    repeat (idle) @(negedge clk);
    @(negedge clk);
    if (arready !== 1'b1) begin
      $display("Mismatch arready before burst %0d: got %h expected %h", n, arready, 1'b1);
      errors++;
    end
    arvalid = 1'b1;
    arid = id;
    araddr = ADDR_W'(word * STRB_W);
    arlen = len;
    arsize = FULL_SIZE;
    arburst = BURST_INCR;
    // the request holds until the splitter takes it
    @(posedge clk);
    while (arready !== 1'b1) @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    beat = 0;
    done = 1'b0;
    held = 1'b0;
    held_data = '0;
    while (!done) begin
      rready = ($urandom % 100) < 70;
      @(posedge clk);
      if (arready !== 1'b0) begin
        $display("Mismatch arready during burst %0d beat %0d: got %h expected %h",
          n, beat, arready, 1'b0);
        errors++;
      end
      // a stalled beat must still be there with the same data
      if (held && rvalid !== 1'b1) begin
        $display("Mismatch rvalid stalled in burst %0d beat %0d: got %h expected %h",
          n, beat, rvalid, 1'b1);
        errors++;
      end else if (held && rdata !== held_data) begin
        $display("Mismatch rdata stalled in burst %0d beat %0d: got %h expected %h",
          n, beat, rdata, held_data);
        errors++;
      end
      if (rvalid === 1'b1 && rready) begin
        expected = image[(word + beat) % IMAGE_WORDS];
        if (rdata !== expected) begin
          $display("Mismatch rdata burst %0d beat %0d: got %h expected %h",
            n, beat, rdata, expected);
          errors++;
        end
        if (rid !== id) begin
          $display("Mismatch rid burst %0d beat %0d: got %h expected %h", n, beat, rid, id);
          errors++;
        end
        if (rresp !== RESP_OKAY) begin
          $display("Mismatch rresp burst %0d beat %0d: got %h expected %h",
            n, beat, rresp, RESP_OKAY);
          errors++;
        end
        if (rlast !== (beat == int'(len))) begin
          $display("Mismatch rlast burst %0d beat %0d: got %h expected %h",
            n, beat, rlast, beat == int'(len));
          errors++;
        end
        // stop on rlast or on the last expected beat if rlast never comes
        if (rlast === 1'b1 || beat >= int'(len)) done = 1'b1;
        beat++;
      end
      held = (rvalid === 1'b1) && !rready;
      held_data = rdata;
      @(negedge clk);
    end
    rready = 1'b0;
    report_test($sformatf("burst %0d id %h word %0d len %0d", n, id, word, len),
      errors_before);
  endtask

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------
  initial begin
    void'($urandom(SEED));
    $readmemh(MEM_FILE, image);
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    arvalid = 1'b0;
    arid = '0;
    araddr = '0;
    arlen = '0;
    arsize = FULL_SIZE;
    arburst = BURST_INCR;
    rready = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();
    for (int n = 0; n < NUM_BURSTS; n++) begin
      run_burst(n);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
      tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // a stuck handshake ends the run here
  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: the bursts did not complete within %0d time units", WATCHDOG_TIME);
    $display("*** FAILED ***");
    $finish;
  end
endmodule

// File: bench/clk_gen.sv
module clk_gen (
  output logic clk
);
  // half of the 100 unit clock period
  localparam int HALF_PERIOD = 50;

  // the clock starts low so the first rising edge comes after half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end
endmodule

// File: src/striped_mem_rd.sv
module striped_mem_rd import stripe_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic arvalid,
  output logic arready,
  input logic [ID_W-1:0] arid,
  input logic [ADDR_W-1:0] araddr,
  input logic [LEN_W-1:0] arlen,
  input logic [SIZE_W-1:0] arsize,
  input logic [BURST_W-1:0] arburst,
  output logic rvalid,
  input logic rready,
  output logic [ID_W-1:0] rid,
  output logic [DATA_W-1:0] rdata,
  output logic [RESP_W-1:0] rresp,
  output logic rlast
);
  // one read link per bank between the splitter and the ROMs
  axi_rd_if bank_if [NUM_BANKS] ();

  // the splitter faces the manager on plain ports
  axi_stripe_rd i_axi_stripe_rd (
    .clk(clk),
    .rst_n(rst_n),
    .arvalid(arvalid),
    .arready(arready),
    .arid(arid),
    .araddr(araddr),
    .arlen(arlen),
    .arsize(arsize),
    .arburst(arburst),
    .rvalid(rvalid),
    .rready(rready),
    .rid(rid),
    .rdata(rdata),
    .rresp(rresp),
    .rlast(rlast),
    .bank(bank_if)
  );

  // bank i holds image words i, i + NUM_BANKS, i + 2 * NUM_BANKS and so on
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    stripe_bank #(
      .BANK(i)
    ) i_stripe_bank (
      .clk(clk),
      .rst_n(rst_n),
      .port(bank_if[i])
    );
  end
endmodule

// File: src/stripe_bank.sv
module stripe_bank import stripe_pkg::*; #(
  parameter int BANK = 0
) (
  input logic clk,
  input logic rst_n,
  axi_rd_if.subordinate port
);
  logic [DATA_W-1:0] image [IMAGE_WORDS];
  logic [DATA_W-1:0] rom [BANK_WORDS];
  logic ar_hs;
  logic r_hs;
  logic [BANK_WORD_W-1:0] start_word;
  // word to present on the next accepted beat
  logic [BANK_WORD_W-1:0] ptr;
  // beats still to send after the one on the bus
  logic [LEN_W-1:0] beats_left;

  // this bank keeps every NUM_BANKS-th image word, starting at its own index
  initial begin
    $readmemh(MEM_FILE, image);
    for (int j = 0; j < BANK_WORDS; j++) begin
      rom[j] = image[j * NUM_BANKS + BANK];
    end
  end

  assign ar_hs = port.arvalid && port.arready;
  assign r_hs = port.rvalid && port.rready;
  assign start_word = port.araddr[STRB_SEL_W +: BANK_WORD_W];
  assign port.rresp = RESP_OKAY;

  // --------------------------------------------------
  // burst engine
  // --------------------------------------------------

  // the bank either waits for a request or sends beats and never does both
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      port.arready <= 1'b1;
      port.rvalid <= 1'b0;
    end else if (ar_hs) begin
      port.arready <= 1'b0;
      port.rvalid <= 1'b1;
    end else if (r_hs && port.rlast) begin
      port.arready <= 1'b1;
      port.rvalid <= 1'b0;
    end
  end

  // the first word is fetched with the request and later words on each accepted beat
  // so the payload stays put while ready is low
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      port.rid <= port.arid;
      port.rdata <= rom[start_word];
      port.rlast <= (port.arlen == '0);
      ptr <= start_word + 1'b1;
      beats_left <= port.arlen;
    end else if (r_hs && !port.rlast) begin
      port.rdata <= rom[ptr];
      port.rlast <= (beats_left == LEN_W'(1));
      // pointer wraps inside the bank on its own width
      ptr <= ptr + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

  // only full width INCR bursts are served
  a_incr_full : assert property (@(posedge clk) disable iff (!rst_n)
    port.arvalid |-> port.arsize == FULL_SIZE && port.arburst == BURST_INCR)
    else $error("bank %0d got an unsupported request", BANK);

  // a stalled beat keeps its data until the splitter takes it
  a_hold_beat : assert property (@(posedge clk) disable iff (!rst_n)
    port.rvalid && !port.rready |=> port.rvalid && $stable(port.rdata))
    else $error("bank %0d dropped or changed a stalled beat", BANK);
endmodule

// File: src/axi_stripe_rd.sv
module axi_stripe_rd import stripe_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic arvalid,
  output logic arready,
  input logic [ID_W-1:0] arid,
  input logic [ADDR_W-1:0] araddr,
  input logic [LEN_W-1:0] arlen,
  input logic [SIZE_W-1:0] arsize,
  input logic [BURST_W-1:0] arburst,
  output logic rvalid,
  input logic rready,
  output logic [ID_W-1:0] rid,
  output logic [DATA_W-1:0] rdata,
  output logic [RESP_W-1:0] rresp,
  output logic rlast,
  axi_rd_if.manager bank [NUM_BANKS]
);
  logic ar_hs;
  logic r_hs;
  logic [NUM_BANKS-1:0] ar_done;
  logic [BANK_SEL_W-1:0] idx;
  // one request is shared by every bank, only the handshakes differ
  logic [ID_W-1:0] ar_id_q;
  logic [BANK_ADDR_W-1:0] ar_addr_q;
  logic [LEN_W-1:0] ar_len_q;
  logic [SIZE_W-1:0] ar_size_q;
  logic [BURST_W-1:0] ar_burst_q;
  // flattened copies of the bank side, so the mux can index by idx
  logic [NUM_BANKS-1:0] bank_arvalid;
  logic [NUM_BANKS-1:0] bank_arready;
  logic [NUM_BANKS-1:0] bank_rvalid;
  logic [NUM_BANKS-1:0][ID_W-1:0] bank_rid;
  logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;
  logic [NUM_BANKS-1:0][RESP_W-1:0] bank_rresp;
  logic [NUM_BANKS-1:0] bank_rlast;

  assign ar_hs = arvalid && arready;
  assign r_hs = rvalid && rready;

  // --------------------------------------------------
  // address channel
  // --------------------------------------------------

  // one burst at a time, the port reopens after the merged rlast beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arready <= 1'b1;
    end else if (ar_hs) begin
      arready <= 1'b0;
    end else if (r_hs && rlast) begin
      arready <= 1'b1;
    end
  end

  // a bank whose request was taken is marked done until the next burst
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ar_done <= '0;
    end else if (ar_hs) begin
      ar_done <= '0;
    end else begin
      ar_done <= ar_done | (bank_arvalid & bank_arready);
    end
  end

  // while busy every bank that has not taken its request keeps asking
  assign bank_arvalid = {NUM_BANKS{!arready}} & ~ar_done;

  // bank select word bits are dropped and the byte bits are zero when aligned
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      ar_id_q <= arid;
      ar_addr_q <= {araddr[ADDR_W-1:STRIPE_LSB], STRB_SEL_W'(0)};
      ar_len_q <= arlen >> BANK_SEL_W;
      ar_size_q <= arsize;
      ar_burst_q <= arburst;
    end
  end

  // --------------------------------------------------
  // data channel
  // --------------------------------------------------

  // beat k of the burst comes from bank k modulo NUM_BANKS
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (ar_hs) begin
      idx <= '0;
    end else if (r_hs) begin
      idx <= idx + 1'b1;
    end
  end

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    assign bank[i].arvalid = bank_arvalid[i];
    assign bank[i].arid = ar_id_q;
    assign bank[i].araddr = ar_addr_q;
    assign bank[i].arlen = ar_len_q;
    assign bank[i].arsize = ar_size_q;
    assign bank[i].arburst = ar_burst_q;
    // only the selected bank sees ready, the others hold their beat
    assign bank[i].rready = rready && (idx == BANK_SEL_W'(i));
    assign bank_arready[i] = bank[i].arready;
    assign bank_rvalid[i] = bank[i].rvalid;
    assign bank_rid[i] = bank[i].rid;
    assign bank_rdata[i] = bank[i].rdata;
    assign bank_rresp[i] = bank[i].rresp;
    assign bank_rlast[i] = bank[i].rlast;
  end

  assign rvalid = bank_rvalid[idx];
  assign rid = bank_rid[idx];
  assign rdata = bank_rdata[idx];
  assign rresp = bank_rresp[idx];
  // every bank ends its own burst, only the last bank ends the merged one
  assign rlast = bank_rlast[idx] && (idx == BANK_SEL_W'(NUM_BANKS - 1));

  // requests must start on a stripe, span full words and cover whole stripes
  a_stripe_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> araddr[STRIPE_LSB-1:0] == '0)
    else $error("araddr %h is not stripe aligned", araddr);
  a_full_size : assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> arsize == FULL_SIZE)
    else $error("arsize %h is not the full data width", arsize);
  a_whole_stripes : assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> ((32'(arlen) + 1) % NUM_BANKS) == 0)
    else $error("arlen %h does not end on a stripe boundary", arlen);
endmodule

// File: src/axi_rd_if.sv
interface axi_rd_if import stripe_pkg::*; ();

  // --------------------------------------------------
  // read address channel
  // --------------------------------------------------
  logic arvalid;
  logic arready;
  logic [ID_W-1:0] arid;
  // byte address inside one bank
  logic [BANK_ADDR_W-1:0] araddr;
  logic [LEN_W-1:0] arlen;
  logic [SIZE_W-1:0] arsize;
  logic [BURST_W-1:0] arburst;

  // --------------------------------------------------
  // read data channel
  // --------------------------------------------------
  logic rvalid;
  logic rready;
  logic [ID_W-1:0] rid;
  logic [DATA_W-1:0] rdata;
  logic [RESP_W-1:0] rresp;
  logic rlast;

  // the splitter side issues requests and takes beats
  modport manager (
    output arvalid, arid, araddr, arlen, arsize, arburst, rready,
    input arready, rvalid, rid, rdata, rresp, rlast
  );

  // the bank side answers requests with beats
  modport subordinate (
    input arvalid, arid, araddr, arlen, arsize, arburst, rready,
    output arready, rvalid, rid, rdata, rresp, rlast
  );
endinterface

// File: src/stripe_pkg.sv
package stripe_pkg;

  // top level addressing is in bytes, one word per data beat
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W = 4;

  // widths of the fixed axi read fields
  localparam int LEN_W = 8;
  localparam int SIZE_W = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W = 2;

  // consecutive words go to consecutive banks, so the bank select bits sit
  // just above the byte lane bits of the address
  localparam int NUM_BANKS = 4;
  localparam int BANK_SEL_W = $clog2(NUM_BANKS);
  localparam int STRB_SEL_W = $clog2(STRB_W);
  localparam int STRIPE_LSB = BANK_SEL_W + STRB_SEL_W;
  localparam int BANK_ADDR_W = ADDR_W - BANK_SEL_W;
  localparam int BANK_WORDS = 16;
  localparam int BANK_WORD_W = $clog2(BANK_WORDS);
  localparam int IMAGE_WORDS = NUM_BANKS * BANK_WORDS;

  // field encodings
  localparam logic [SIZE_W-1:0] FULL_SIZE = SIZE_W'(STRB_SEL_W);
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;
  localparam string MEM_FILE = "mem_image.hex";
endpackage
